// ==== hw/modemPkg.sv ====
package modemPkg;

	////////////////////////////////////////////////////////////
	// Symbol format
	////////////////////////////////////////////////////////////

	typedef logic signed [3:0] sampleT; // One axis value

	typedef struct packed {
		sampleT i; // In-phase
		sampleT q; // Quadrature
	} symbolT;

	typedef logic [3:0] nibbleT; // First received bit in bit 3

	////////////////////////////////////////////////////////////
	// Constellation
	////////////////////////////////////////////////////////////

	localparam sampleT LevelNeg3 = -4'sd3;
	localparam sampleT LevelNeg1 = -4'sd1;
	localparam sampleT LevelPos1 = 4'sd1;
	localparam sampleT LevelPos3 = 4'sd3;

	// Decision points halfway between adjacent levels
	localparam sampleT SliceNeg2 = -4'sd2;
	localparam sampleT SliceZero = 4'sd0;
	localparam sampleT SlicePos2 = 4'sd2;

	// Gray rule, neighbours differ in one bit
	function automatic sampleT grayLevel(input logic [1:0] pair);
		case (pair)
			2'b00:   return LevelNeg3;
			2'b01:   return LevelNeg1;
			2'b11:   return LevelPos1;
			default: return LevelPos3; // Pair 10
		endcase
	endfunction

endpackage

// ==== hw/ctrlPkg.sv ====
package ctrlPkg;

	////////////////////////////////////////////////////////////
	// Demapper control
	////////////////////////////////////////////////////////////

	typedef enum logic {
		DemapIdle  = 1'b0, // Waiting for a symbol
		DemapShift = 1'b1  // Sending the four bits
	} demapStateT;

	////////////////////////////////////////////////////////////
	// Buffer status
	////////////////////////////////////////////////////////////

	typedef struct packed {
		logic empty;    // No symbol stored
		logic full;     // No room for a write
		logic overflow; // Sticky, a write was lost
	} fifoStatusT;

endpackage

// ==== hw/qamMapper.sv ====
module qamMapper (
	input  logic             inClock,
	input  logic             rstN,
	input  logic             inBit,
	input  logic             inBitValid,
	output modemPkg::symbolT mapSymbol,
	output logic             mapStrobe
);

	import modemPkg::*;

	////////////////////////////////////////////////////////////
	// Bit gathering
	////////////////////////////////////////////////////////////

	logic [2:0] shiftReg;   // Bits already taken, oldest on top
	logic [1:0] bitCount;   // Bits taken in the current nibble
	logic       lastBit;    // Fourth bit arriving now
	nibbleT     fullNibble; // Stored bits plus the incoming one

	assign fullNibble = {shiftReg, inBit};
	assign lastBit    = inBitValid && (bitCount == 2'd3);

	// Count wraps after four bits
	always_ff @(posedge inClock) begin
		if (!rstN) begin
			bitCount  <= 2'd0;
			mapStrobe <= 1'b0;
		end else begin
			mapStrobe <= lastBit; // One cycle after the fourth bit
			if (inBitValid) begin
				bitCount <= bitCount + 2'd1;
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Symbol mapping
	////////////////////////////////////////////////////////////

	// A partial nibble is held while inBitValid is low
	always_ff @(posedge inClock) begin
		if (inBitValid) begin
			shiftReg <= fullNibble[2:0];
		end
		if (lastBit) begin
			mapSymbol.i <= grayLevel(fullNibble[3:2]); // Upper pair
			mapSymbol.q <= grayLevel(fullNibble[1:0]); // Lower pair
		end
	end

endmodule

// ==== hw/symbolFifo.sv ====
module symbolFifo #(
	parameter int FifoDepth = 8 // Power of two
) (
	input  logic                inClock,
	input  logic                rstN,
	input  modemPkg::symbolT    mapSymbol,
	input  logic                mapStrobe,
	input  logic                popStrobe,
	output modemPkg::symbolT    headSymbol,
	output ctrlPkg::fifoStatusT fifoStatus
);

	import modemPkg::*;
	import ctrlPkg::*;

	localparam int PtrWidth = $clog2(FifoDepth);

	////////////////////////////////////////////////////////////
	// Storage and pointers
	////////////////////////////////////////////////////////////

	symbolT              store [FifoDepth]; // Circular symbol store
	logic [PtrWidth-1:0] wrPtr;
	logic [PtrWidth-1:0] rdPtr;
	logic [PtrWidth:0]   count;             // Occupancy, 0 to FifoDepth
	logic                isEmpty;
	logic                isFull;
	logic                wrAccept;          // Write that finds room
	logic                overflowFlag;

	assign isEmpty  = (count == '0);
	assign isFull   = (count == (PtrWidth + 1)'(FifoDepth));
	assign wrAccept = mapStrobe && !isFull;

	// Pointers wrap by their width
	always_ff @(posedge inClock) begin
		if (!rstN) begin
			wrPtr        <= '0;
			rdPtr        <= '0;
			count        <= '0;
			overflowFlag <= 1'b0;
		end else begin
			if (wrAccept) begin
				wrPtr <= wrPtr + 1'b1;
			end
			if (popStrobe) begin
				rdPtr <= rdPtr + 1'b1; // Caller checks emptiness
			end
			case ({wrAccept, popStrobe})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count; // Both or neither
			endcase
			if (mapStrobe && isFull) begin
				overflowFlag <= 1'b1; // Held until reset
			end
		end
	end

	always_ff @(posedge inClock) begin
		if (wrAccept) begin
			store[wrPtr] <= mapSymbol;
		end
	end

	////////////////////////////////////////////////////////////
	// Outputs
	////////////////////////////////////////////////////////////

	assign headSymbol = store[rdPtr]; // Oldest entry

	assign fifoStatus = '{
		empty:    isEmpty,
		full:     isFull,
		overflow: overflowFlag
	};

endmodule

// ==== hw/qamDemapper.sv ====
module qamDemapper (
	input  logic                inClock,
	input  logic                rstN,
	input  modemPkg::symbolT    headSymbol,
	input  ctrlPkg::fifoStatusT fifoStatus,
	input  logic                outEnable,
	output logic                popStrobe,
	output logic                outBit,
	output logic                outBitValid
);

	import modemPkg::*;
	import ctrlPkg::*;

	////////////////////////////////////////////////////////////
	// Slicer
	////////////////////////////////////////////////////////////

	// Nearest level back to its Gray pair
	function automatic logic [1:0] slicePair(input sampleT level);
		if (level < SliceNeg2) begin
			return 2'b00;
		end else if (level < SliceZero) begin
			return 2'b01;
		end else if (level < SlicePos2) begin
			return 2'b11;
		end else begin
			return 2'b10;
		end
	endfunction

	demapStateT state;
	logic [1:0] shiftCount;   // Bits left after the current one
	nibbleT     shiftReg;     // Current bit on top
	nibbleT     slicedNibble;

	assign slicedNibble = {slicePair(headSymbol.i), slicePair(headSymbol.q)};

	// Pop only from idle with data and permission
	assign popStrobe = (state == DemapIdle) && !fifoStatus.empty && outEnable;

	////////////////////////////////////////////////////////////
	// Control
	////////////////////////////////////////////////////////////

	always_ff @(posedge inClock) begin
		if (!rstN) begin
			state      <= DemapIdle;
			shiftCount <= 2'd0;
		end else begin
			case (state)
				DemapIdle: begin
					if (popStrobe) begin
						state      <= DemapShift;
						shiftCount <= 2'd3;
					end
				end
				DemapShift: begin
					shiftCount <= shiftCount - 2'd1;
					if (shiftCount == 2'd0) begin
						state <= DemapIdle; // Burst done, ignores outEnable
					end
				end
				default: state <= DemapIdle;
			endcase
		end
	end

	// Nibble register, loaded on the pop
	always_ff @(posedge inClock) begin
		if (popStrobe) begin
			shiftReg <= slicedNibble;
		end else if (state == DemapShift) begin
			shiftReg <= {shiftReg[2:0], 1'b0};
		end
	end

	assign outBit      = shiftReg[3]; // Most significant first
	assign outBitValid = (state == DemapShift);

endmodule

// ==== hw/modemTop.sv ====
module modemTop #(
	parameter int FifoDepth = 8 // Buffer size in symbols
) (
	input  logic             inClock,
	input  logic             rstN,
	input  logic             inBit,
	input  logic             inBitValid,
	input  logic             outEnable,
	output logic             outBit,
	output logic             outBitValid,
	output modemPkg::symbolT lineSymbol,
	output logic             lineValid,
	output logic             overflow
);

	import modemPkg::*;
	import ctrlPkg::*;

	symbolT     mapSymbol;  // Mapper to buffer
	logic       mapStrobe;
	symbolT     headSymbol; // Buffer to demapper
	fifoStatusT fifoStatus;
	logic       popStrobe;  // Demapper back to buffer

	////////////////////////////////////////////////////////////
	// Transmit side
	////////////////////////////////////////////////////////////

	qamMapper qamMapper_i (
		.inClock    (inClock),
		.rstN       (rstN),
		.inBit      (inBit),
		.inBitValid (inBitValid),
		.mapSymbol  (mapSymbol),
		.mapStrobe  (mapStrobe)
	);

	symbolFifo #(
		.FifoDepth (FifoDepth)
	) symbolFifo_i (
		.inClock    (inClock),
		.rstN       (rstN),
		.mapSymbol  (mapSymbol),
		.mapStrobe  (mapStrobe),
		.popStrobe  (popStrobe),
		.headSymbol (headSymbol),
		.fifoStatus (fifoStatus)
	);

	////////////////////////////////////////////////////////////
	// Receive side
	////////////////////////////////////////////////////////////

	qamDemapper qamDemapper_i (
		.inClock     (inClock),
		.rstN        (rstN),
		.headSymbol  (headSymbol),
		.fifoStatus  (fifoStatus),
		.outEnable   (outEnable),
		.popStrobe   (popStrobe),
		.outBit      (outBit),
		.outBitValid (outBitValid)
	);

	assign lineSymbol = headSymbol;          // Symbol on the line at each pop
	assign lineValid  = popStrobe;
	assign overflow   = fifoStatus.overflow;

endmodule

// ==== verification/tbModemTop.sv ====
module tbModemTop;

	timeunit 1ns;
	timeprecision 1ps;

	import modemPkg::*;

	localparam int FifoDepth    = 8;
	localparam int DrainTimeout = 400; // Cycles

	logic   inClock;
	logic   rstN;
	logic   inBit;
	logic   inBitValid;
	logic   outEnable;
	logic   outBit;
	logic   outBitValid;
	symbolT lineSymbol;
	logic   lineValid;
	logic   overflow;

	nibbleT refNibbles [$]; // Nibbles still due on the line
	logic   refBits [$];    // Bits still due at the output
	int     errorCount;
	int     testCount;
	int     burstLeft;      // outBitValid cycles still due
	logic   busy;
	symbolT expSym;
	logic   expBit;
	logic   sendDone;

	modemTop #(
		.FifoDepth (FifoDepth)
	) modemTop_i (
		.inClock     (inClock),
		.rstN        (rstN),
		.inBit       (inBit),
		.inBitValid  (inBitValid),
		.outEnable   (outEnable),
		.outBit      (outBit),
		.outBitValid (outBitValid),
		.lineSymbol  (lineSymbol),
		.lineValid   (lineValid),
		.overflow    (overflow)
	);

	initial inClock = 1'b0;
	always #5 inClock = ~inClock;

	////////////////////////////////////////////////////////////
	// Reference model
	////////////////////////////////////////////////////////////

	// Pairs ending in 1 sit next to zero and the upper bit gives the sign
	function automatic sampleT expectedLevel(input logic [1:0] pair);
		sampleT mag;
		mag = pair[0] ? 4'sd1 : 4'sd3;
		return pair[1] ? mag : -mag;
	endfunction

	function automatic symbolT expectedSymbol(input nibbleT nib);
		symbolT sym;
		sym.i = expectedLevel(nib[3:2]);
		sym.q = expectedLevel(nib[1:0]);
		return sym;
	endfunction

	task automatic reportValue(input string name, input logic [7:0] got,
			input logic [7:0] exp);
		errorCount++;
		$display("Error at %0d ns: %s is %h, expected %h", $time, name, got, exp);
	endtask

	task automatic reportText(input string what);
		errorCount++;
		$display("At %0d ns: %s", $time, what);
	endtask

	////////////////////////////////////////////////////////////
	// Checkers
	////////////////////////////////////////////////////////////

	resetQuiet: assert property (@(posedge inClock)
		!rstN |=> (!outBitValid && !lineValid && !overflow))
		else reportText("outBitValid, lineValid or overflow high during or just after reset");

	overflowSticky: assert property (@(posedge inClock) disable iff (!rstN)
		overflow |=> overflow)
		else reportValue("overflow", $sampled(overflow), 8'd1);

	burstFollows: assert property (@(posedge inClock) disable iff (!rstN)
		lineValid |=> outBitValid)
		else reportValue("outBitValid", $sampled(outBitValid), 8'd1);

	burstEnds: assert property (@(posedge inClock) disable iff (!rstN)
		lineValid |-> ##5 !outBitValid)
		else reportValue("outBitValid", $sampled(outBitValid), 8'd0);

	// Mid-cycle view of the line and the bit output
	always @(negedge inClock) begin
		if (rstN !== 1'b1) begin
			burstLeft = 0;
		end else begin
			busy = (burstLeft > 0);
			assert (outBitValid === busy) else reportValue("outBitValid", outBitValid, busy);
			if (busy) begin
				burstLeft--;
			end
			if (lineValid) begin
				assert (!busy) else reportText("lineValid while a bit burst was running");
				burstLeft = 4; // Bits in cycles 1 to 4
				if (refNibbles.size() == 0) begin
					reportText("lineValid with no symbol outstanding");
				end else begin
					expSym = expectedSymbol(refNibbles.pop_front());
					assert (lineSymbol === expSym) else reportValue("lineSymbol", lineSymbol, expSym);
				end
			end
			if (outBitValid) begin
				if (refBits.size() == 0) begin
					reportText("outBitValid with no bit outstanding");
				end else begin
					expBit = refBits.pop_front();
					assert (outBit === expBit) else reportValue("outBit", outBit, expBit);
				end
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Stimulus tasks
	////////////////////////////////////////////////////////////

	task automatic applyReset();
		repeat (5) @(posedge inClock);
		rstN <= 1'b1;
	endtask

	task automatic driveIdle(input int cycles);
		repeat (cycles) begin
			@(posedge inClock);
			inBitValid <= 1'b0;
		end
	endtask

	// First bit waits at least a cycle so input never outruns the 5-cycle burst
	task automatic sendSymbol(input nibbleT nib, input int maxGap, input logic expectOut);
		int gap;
		for (int k = 3; k >= 0; k--) begin
			gap = $urandom_range(maxGap, 0);
			if (k == 3) begin
				gap++;
			end
			driveIdle(gap);
			@(posedge inClock);
			inBit      <= nib[k];
			inBitValid <= 1'b1;
		end
		if (expectOut) begin
			refNibbles.push_back(nib);
			for (int k = 3; k >= 0; k--) begin
				refBits.push_back(nib[k]);
			end
		end
	endtask

	task automatic waitDrained(input int limit);
		int cycles;
		cycles = 0;
		while ((refBits.size() != 0 || outBitValid) && cycles < limit) begin
			@(negedge inClock);
			cycles++;
		end
		if (refBits.size() != 0) begin
			reportText($sformatf("timeout, %0d bits never came out", refBits.size()));
		end
	endtask

	task automatic waitOverflow(input int limit);
		int cycles;
		cycles = 0;
		while (!overflow && cycles < limit) begin
			@(negedge inClock);
			cycles++;
		end
		if (!overflow) begin
			reportText("timeout, overflow never rose after a write into a full buffer");
		end
	endtask

	task automatic finishTest(input string name, input int startErrors);
		testCount++;
		$display("Test %-12s done, %0d error(s)", name, errorCount - startErrors);
	endtask

	////////////////////////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////////////////////////

	initial begin
		int startErrors;
		void'($urandom(32'hb04f_1377));
		errorCount = 0;
		testCount  = 0;
		sendDone   = 1'b0;
		rstN       = 1'b0;
		inBit      = 1'b0;
		inBitValid = 1'b0;
		outEnable  = 1'b0;

		startErrors = errorCount;
		applyReset();
		@(negedge inClock); // First cycle out of reset
		assert (!outBitValid && !lineValid && !overflow)
			else reportText("outputs not quiet on the first cycle after reset");
		finishTest("reset", startErrors);

		// Every constellation point once
		startErrors = errorCount;
		@(posedge inClock);
		outEnable <= 1'b1;
		for (int n = 0; n < 16; n++) begin
			sendSymbol(nibbleT'(n), 0, 1'b1);
		end
		driveIdle(1);
		waitDrained(DrainTimeout);
		finishTest("mapping", startErrors);

		startErrors = errorCount;
		for (int n = 0; n < 40; n++) begin
			sendSymbol(nibbleT'($urandom_range(15, 0)), 3, 1'b1);
		end
		driveIdle(1);
		waitDrained(DrainTimeout);
		assert (!overflow) else reportValue("overflow", overflow, 8'd0);
		finishTest("round trip", startErrors);

		// outEnable wanders while bursts are running
		startErrors = errorCount;
		sendDone    = 1'b0;
		fork
			begin
				for (int n = 0; n < 12; n++) begin
					sendSymbol(nibbleT'($urandom_range(15, 0)), 1, 1'b1);
				end
				driveIdle(1);
				sendDone <= 1'b1;
			end
			begin
				while (!sendDone) begin
					@(posedge inClock);
					outEnable <= 1'($urandom_range(1, 0));
				end
			end
		join
		@(posedge inClock);
		outEnable <= 1'b1;
		waitDrained(DrainTimeout);
		assert (!overflow) else reportValue("overflow", overflow, 8'd0);
		finishTest("burst shape", startErrors);

		startErrors = errorCount;
		@(posedge inClock);
		outEnable <= 1'b0;
		for (int n = 0; n < FifoDepth + 3; n++) begin
			sendSymbol(nibbleT'($urandom_range(15, 0)), 1, n < FifoDepth);
			if (n == FifoDepth - 1) begin
				driveIdle(3); // Buffer now full
				@(negedge inClock);
				assert (!overflow) else reportValue("overflow", overflow, 8'd0);
			end
			if (n == FifoDepth) begin
				driveIdle(1);
				waitOverflow(10);
			end
		end
		driveIdle(4);
		@(negedge inClock);
		assert (overflow) else reportValue("overflow", overflow, 8'd1);
		assert (refNibbles.size() == FifoDepth)
			else reportText("symbols left the buffer while outEnable was low");
		@(posedge inClock);
		outEnable <= 1'b1;
		waitDrained(DrainTimeout);
		driveIdle(20); // Any dropped symbol would show up here
		@(negedge inClock);
		assert (refNibbles.size() == 0) else reportText("stored symbols never reached the line");
		assert (overflow) else reportValue("overflow", overflow, 8'd1);
		finishTest("overflow", startErrors);

		$display("Tests run: %0d, errors: %0d", testCount, errorCount);
		if (errorCount == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule

// ==== modem.f ====
hw/modemPkg.sv
hw/ctrlPkg.sv
hw/qamMapper.sv
hw/symbolFifo.sv
hw/qamDemapper.sv
hw/modemTop.sv
verification/tbModemTop.sv

// ==== Bender.yml ====
package:
  name: modem

sources:
  - hw/modemPkg.sv
  - hw/ctrlPkg.sv
  - hw/qamMapper.sv
  - hw/symbolFifo.sv
  - hw/qamDemapper.sv
  - hw/modemTop.sv
  - target: simulation
    files:
      - verification/tbModemTop.sv
